// File: compile.f
fp_format_pkg.sv
fpmul_bus_pkg.sv
fp_mul_core.sv
fpmul_lane_array.sv
fpmul_cfg_regs.sv
fpmul_top.sv
fpmul_props.sv
tb_fpmul.sv

// File: fp_format_pkg.sv
package fp_format_pkg;

    // ------------------------------------------------------------------------
    // vector and word types
    // ------------------------------------------------------------------------

    // one full operand or result vector
    typedef logic [127:0] vec128_t;

    // single precision word
    typedef logic [31:0] fp32_t;

    // half precision word
    typedef logic [15:0] fp16_t;

    // ------------------------------------------------------------------------
    // format geometry
    // ------------------------------------------------------------------------

    // ieee binary32 field widths
    localparam int FP32_EXP_W  = 8;
    localparam int FP32_MANT_W = 23;

    // ieee binary16 field widths
    localparam int FP16_EXP_W  = 5;
    localparam int FP16_MANT_W = 10;

    // lanes per 128-bit vector
    localparam int FP32_LANES = 4;
    localparam int FP16_LANES = 8;

    // ------------------------------------------------------------------------
    // precision mode
    // ------------------------------------------------------------------------

    // mode register value taken from bit 0 of the written data
    typedef enum logic {
        MODE_FP16 = 1'b0,
        MODE_FP32 = 1'b1
    } prec_mode_e;

endpackage

// File: fp_mul_core.sv
`timescale 1ns/10ps

module fp_mul_core #(
    parameter int EXP_W = fp_format_pkg::FP32_EXP_W,
    parameter int MANT_W = fp_format_pkg::FP32_MANT_W,
    localparam int W = EXP_W + MANT_W + 1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [W-1:0] a,
    input  logic [W-1:0] b,
    output logic [W-1:0] result
);

    // full width of the hidden-bit product
    localparam int P_W = 2 * (MANT_W + 1);
    // signed exponent width with room for both overflow and underflow
    localparam int ES_W = EXP_W + 2;
    localparam int BIAS = (1 << (EXP_W - 1)) - 1;
    localparam int EXP_MAX = (1 << EXP_W) - 1;

    // ------------------------------------------------------------------------
    // stage 1 unpacks, classifies and multiplies
    // ------------------------------------------------------------------------

    logic              sign_a;
    logic              sign_b;
    logic [EXP_W-1:0]  exp_a;
    logic [EXP_W-1:0]  exp_b;
    logic [MANT_W-1:0] man_a;
    logic [MANT_W-1:0] man_b;

    logic a_zero;
    logic b_zero;
    logic a_inf;
    logic b_inf;
    logic a_nan;
    logic b_nan;

    logic signed [ES_W-1:0] exp_sum_c;
    logic [P_W-1:0]         prod_c;

    assign {sign_a, exp_a, man_a} = a;
    assign {sign_b, exp_b, man_b} = b;

    // subnormals fall into the zero class
    assign a_zero = (exp_a == '0);
    assign b_zero = (exp_b == '0);
    assign a_inf  = (exp_a == '1) && (man_a == '0);
    assign b_inf  = (exp_b == '1) && (man_b == '0);
    assign a_nan  = (exp_a == '1) && (man_a != '0);
    assign b_nan  = (exp_b == '1) && (man_b != '0);

    // unbiased sum of both exponents
    assign exp_sum_c = {2'b00, exp_a} + {2'b00, exp_b} - ES_W'(2 * BIAS);

    assign prod_c = P_W'({1'b1, man_a}) * P_W'({1'b1, man_b});

    logic                   s1_sign;
    logic                   s1_nan;
    logic                   s1_zero;
    logic                   s1_inf;
    logic signed [ES_W-1:0] s1_exp;
    logic [P_W-1:0]         s1_prod;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_sign <= 1'b0;
            s1_nan  <= 1'b0;
            s1_zero <= 1'b0;
            s1_inf  <= 1'b0;
            s1_exp  <= '0;
            s1_prod <= '0;
        end else begin
            s1_sign <= sign_a ^ sign_b;
            // inf times zero lands here too
            s1_nan  <= a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero);
            s1_zero <= a_zero || b_zero;
            s1_inf  <= a_inf || b_inf;
            s1_exp  <= exp_sum_c;
            s1_prod <= prod_c;
        end
    end

    // ------------------------------------------------------------------------
    // stage 2 normalizes, rounds and packs
    // ------------------------------------------------------------------------

    logic                   norm;
    logic [P_W-1:0]         prod_n;
    logic [MANT_W-1:0]      mant_t;
    logic                   guard;
    logic                   rnd;
    logic                   sticky;
    logic                   round_up;
    logic [MANT_W:0]        mant_r;
    logic signed [ES_W-1:0] exp_f;
    logic                   ovf;
    logic                   unf;
    logic [W-1:0]           res_c;

    // product of two values in [1,2) needs at most one shift
    assign norm   = s1_prod[P_W-1];
    assign prod_n = norm ? s1_prod : {s1_prod[P_W-2:0], 1'b0};

    // explicit mantissa sits just below the leading one
    assign mant_t = prod_n[P_W-2 -: MANT_W];
    assign guard  = prod_n[MANT_W];
    assign rnd    = prod_n[MANT_W-1];
    assign sticky = |prod_n[MANT_W-2:0];

    // ties round to an even lsb
    assign round_up = guard && (rnd || sticky || mant_t[0]);
    assign mant_r   = {1'b0, mant_t} + (MANT_W + 1)'(round_up);

    // carry out of rounding leaves a zero mantissa and one more exponent step
    assign exp_f = s1_exp + ES_W'(BIAS) + ES_W'(norm) + ES_W'(mant_r[MANT_W]);

    assign ovf = (exp_f >= EXP_MAX);
    assign unf = (exp_f < 1);

    always_comb begin
        if (s1_nan) begin
            // canonical quiet nan
            res_c = {s1_sign, {EXP_W{1'b1}}, 1'b1, {(MANT_W - 1){1'b0}}};
        end else if (s1_zero) begin
            res_c = {s1_sign, {(W - 1){1'b0}}};
        end else if (s1_inf || ovf) begin
            res_c = {s1_sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (unf) begin
            // flush to signed zero
            res_c = {s1_sign, {(W - 1){1'b0}}};
        end else begin
            res_c = {s1_sign, exp_f[EXP_W-1:0], mant_r[MANT_W-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= res_c;
        end
    end

endmodule

// File: fpmul_bus_pkg.sv
package fpmul_bus_pkg;

    // ------------------------------------------------------------------------
    // wishbone classic register port
    // ------------------------------------------------------------------------

    // register word address
    typedef logic [3:0] wb_addr_t;

    // register data word
    typedef logic [31:0] wb_data_t;

    // master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    // slave to master with dat only meaningful while ack is high
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // ------------------------------------------------------------------------
    // operand and result streams
    // ------------------------------------------------------------------------

    // both source vectors sampled on every cycle that valid is high
    typedef struct packed {
        logic                   valid;
        fp_format_pkg::vec128_t s0;
        fp_format_pkg::vec128_t s1;
    } vec_req_t;

    // product vector valid for one cycle per request
    typedef struct packed {
        logic                   valid;
        fp_format_pkg::vec128_t data;
    } vec_rsp_t;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------

    // precision select where bit 0 set means fp32
    localparam wb_addr_t REG_MODE = 4'd0;

    // completed vector operations cleared by a write
    localparam wb_addr_t REG_OPCOUNT = 4'd1;

endpackage

// File: fpmul_cfg_regs.sv
`timescale 1ns/10ps

module fpmul_cfg_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fpmul_bus_pkg::wb_req_t    wb_i,
    input  logic                      done,
    output fpmul_bus_pkg::wb_rsp_t    wb_o,
    output fp_format_pkg::prec_mode_e mode
);

    import fp_format_pkg::*;
    import fpmul_bus_pkg::*;

    logic       ack_q;
    prec_mode_e mode_q;
    wb_data_t   op_count;
    wb_data_t   rd_data;

    logic access;
    logic wr_en;
    logic clr_count;

    // ------------------------------------------------------------------------
    // bus decode
    // ------------------------------------------------------------------------

    // first cycle of a cycle/strobe pair before the ack
    assign access    = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr_en     = access && wb_i.we;
    assign clr_count = wr_en && (wb_i.adr == REG_OPCOUNT);

    // ------------------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            mode_q   <= MODE_FP16;
            op_count <= '0;
        end else begin
            // single-cycle ack
            ack_q <= access;

            // takes effect on the edge the ack rises
            if (wr_en && (wb_i.adr == REG_MODE)) begin
                mode_q <= wb_i.dat[0] ? MODE_FP32 : MODE_FP16;
            end

            // clear has priority over a completing operation
            if (clr_count) begin
                op_count <= '0;
            end else if (done) begin
                op_count <= op_count + 32'd1;
            end
        end
    end

    // read data captured alongside the ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (wb_i.adr)
                REG_MODE:    rd_data <= wb_data_t'(mode_q);
                REG_OPCOUNT: rd_data <= op_count;
                default:     rd_data <= '0;
            endcase
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rd_data;
    assign mode     = mode_q;

endmodule

// File: fpmul_lane_array.sv
`timescale 1ns/10ps

module fpmul_lane_array #(
    parameter int N32 = fp_format_pkg::FP32_LANES,
    parameter int N16 = fp_format_pkg::FP16_LANES
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  fpmul_bus_pkg::vec_req_t   req_i,
    input  fp_format_pkg::prec_mode_e mode,
    output fpmul_bus_pkg::vec_rsp_t   rsp_o,
    output logic                      done
);

    import fp_format_pkg::*;
    import fpmul_bus_pkg::*;

    localparam int W32 = $bits(fp32_t);
    localparam int W16 = $bits(fp16_t);

    vec128_t res32;
    vec128_t res16;

    // ------------------------------------------------------------------------
    // both lane sets run on every cycle
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < N32; i++) begin : g_fp32
        fp32_t r;

        fp_mul_core #(
            .EXP_W  (FP32_EXP_W),
            .MANT_W (FP32_MANT_W)
        ) fp_mul_core_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .a      (req_i.s0[i*W32 +: W32]),
            .b      (req_i.s1[i*W32 +: W32]),
            .result (r)
        );

        assign res32[i*W32 +: W32] = r;
    end

    for (genvar j = 0; j < N16; j++) begin : g_fp16
        fp16_t r;

        fp_mul_core #(
            .EXP_W  (FP16_EXP_W),
            .MANT_W (FP16_MANT_W)
        ) fp_mul_core_inst (
            .clk    (clk),
            .rst_n  (rst_n),
            .a      (req_i.s0[j*W16 +: W16]),
            .b      (req_i.s1[j*W16 +: W16]),
            .result (r)
        );

        assign res16[j*W16 +: W16] = r;
    end

    // ------------------------------------------------------------------------
    // valid and mode follow the two core stages
    // ------------------------------------------------------------------------

    logic       valid_d1;
    logic       valid_d2;
    prec_mode_e mode_d1;
    prec_mode_e mode_d2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
            mode_d1  <= MODE_FP16;
            mode_d2  <= MODE_FP16;
        end else begin
            valid_d1 <= req_i.valid;
            valid_d2 <= valid_d1;
            mode_d1  <= mode;
            mode_d2  <= mode_d1;
        end
    end

    // result set picked by the mode captured with the request
    assign rsp_o.valid = valid_d2;
    assign rsp_o.data  = (mode_d2 == MODE_FP32) ? res32 : res16;
    assign done        = valid_d2;

endmodule

// File: fpmul_props.sv
`timescale 1ns/10ps

module fpmul_props (
    input logic                    clk,
    input logic                    rst_n,
    input fpmul_bus_pkg::wb_req_t  wb_i,
    input fpmul_bus_pkg::wb_rsp_t  wb_o,
    input fpmul_bus_pkg::vec_req_t req_i,
    input fpmul_bus_pkg::vec_rsp_t rsp_o
);

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.ack |=> !wb_o.ack)
        else $error("wishbone ack high for more than one cycle");

    // ack only answers a strobe seen on the edge before
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.ack |-> $past(wb_i.cyc && wb_i.stb))
        else $error("wishbone ack without a preceding strobe");

    // fixed two-stage pipeline without stalls
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_o.valid == $past(req_i.valid, 2))
        else $error("response valid not two cycles after request valid");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !rsp_o.valid)
        else $error("response valid high during reset");

endmodule

bind fpmul_top fpmul_props fpmul_props_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_i  (wb_i),
    .wb_o  (wb_o),
    .req_i (req_i),
    .rsp_o (rsp_o)
);

// File: fpmul_top.sv
`timescale 1ns/10ps

module fpmul_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fpmul_bus_pkg::wb_req_t  wb_i,
    input  fpmul_bus_pkg::vec_req_t req_i,
    output fpmul_bus_pkg::wb_rsp_t  wb_o,
    output fpmul_bus_pkg::vec_rsp_t rsp_o
);

    import fp_format_pkg::*;

    // precision from the register block
    prec_mode_e mode;

    // one pulse per completed vector
    logic done;

    // ------------------------------------------------------------------------
    // configuration block
    // ------------------------------------------------------------------------

    fpmul_cfg_regs fpmul_cfg_regs_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_i),
        .done  (done),
        .wb_o  (wb_o),
        .mode  (mode)
    );

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    fpmul_lane_array #(
        .N32 (FP32_LANES),
        .N16 (FP16_LANES)
    ) fpmul_lane_array_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req_i),
        .mode  (mode),
        .rsp_o (rsp_o),
        .done  (done)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fpmul -f compile.f -o sim_fpmul \
    || { echo "verilator build failed"; exit 1; }

result=$(./obj_dir/sim_fpmul)
echo "$result"
echo "$result" | grep -qx "Test OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_fpmul.sv
`timescale 1ns/10ps

module tb_fpmul;

    import fp_format_pkg::*;
    import fpmul_bus_pkg::*;

    localparam int TIMEOUT = 100;

    // fp16 special lanes from lane 0 upward are inf*0 inf*1 nan*1 sub*inf sub*1
    // max*max -min*min and -1*0 with lane 0 as the last entry of each list
    localparam vec128_t SP16_A = {16'hbc00, 16'h8400, 16'h7bff, 16'h0001,
                                  16'h0001, 16'h7e00, 16'h7c00, 16'h7c00};
    localparam vec128_t SP16_B = {16'h0000, 16'h0400, 16'h7bff, 16'h3c00,
                                  16'h7c00, 16'h3c00, 16'h3c00, 16'h0000};
    localparam vec128_t SP32_A0 = {32'h7f7fffff, 32'h00000001, 32'h7fa00000, 32'h7f800000};
    localparam vec128_t SP32_B0 = {32'h40000000, 32'h7f800000, 32'h3f800000, 32'h00000000};
    localparam vec128_t SP32_A1 = {32'hbf800000, 32'h00000001, 32'h80800000, 32'hff800000};
    localparam vec128_t SP32_B1 = {32'h00000000, 32'h3f800000, 32'h00800000, 32'h3f800000};

    logic     clk;
    logic     rst_n;
    wb_req_t  wb_i;
    wb_rsp_t  wb_o;
    vec_req_t req_i;
    vec_rsp_t rsp_o;

    vec128_t    exp_q[$];
    prec_mode_e cur_mode  = MODE_FP16;
    int         errors    = 0;
    int         err_mark  = 0;
    int         checks    = 0;
    int         issued    = 0;
    int         responses = 0;

    fpmul_top fpmul_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .wb_i  (wb_i),
        .req_i (req_i),
        .wb_o  (wb_o),
        .rsp_o (rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] ref_fmul(input logic [31:0] a, input logic [31:0] b,
                                             input int ew, input int mw);
        logic [63:0] emax;
        logic [63:0] mmask;
        logic [63:0] sign;
        logic [63:0] p;
        logic [63:0] q;
        logic [63:0] rem;
        logic [63:0] half;
        int          ea;
        int          eb;
        int          e;
        int          sh;
        emax  = (64'd1 << ew) - 1;
        mmask = (64'd1 << mw) - 1;
        sign  = 64'((a ^ b) >> (ew + mw)) & 64'd1;
        ea    = int'((a >> mw) & emax);
        eb    = int'((b >> mw) & emax);
        // nan operand or inf against zero or subnormal
        if ((ea == emax && (a & mmask) != 0) || (eb == emax && (b & mmask) != 0) ||
            (ea == emax && eb == 0) || (eb == emax && ea == 0)) begin
            return 32'((sign << (ew + mw)) | (emax << mw) | (64'd1 << (mw - 1)));
        end
        if (ea == 0 || eb == 0) return 32'(sign << (ew + mw));
        if (ea == emax || eb == emax) return 32'((sign << (ew + mw)) | (emax << mw));
        p  = ((64'd1 << mw) | (a & mmask)) * ((64'd1 << mw) | (b & mmask));
        e  = ea + eb - int'(emax >> 1);
        sh = ((p >> (2 * mw + 1)) != 0) ? mw + 1 : mw;
        e  = e + sh - mw;
        q    = p >> sh;
        rem  = p & ((64'd1 << sh) - 1);
        half = 64'd1 << (sh - 1);
        if (rem > half || (rem == half && q[0])) q = q + 1;
        // rounding carried into a new leading bit
        if ((q >> (mw + 1)) != 0) begin
            q = q >> 1;
            e = e + 1;
        end
        if (e >= int'(emax)) return 32'((sign << (ew + mw)) | (emax << mw));
        if (e < 1) return 32'(sign << (ew + mw));
        return 32'((sign << (ew + mw)) | (64'(e) << mw) | (q & mmask));
    endfunction

    function automatic vec128_t expect_vec(input vec128_t s0, input vec128_t s1,
                                           input prec_mode_e m);
        vec128_t r;
        if (m == MODE_FP32) begin
            for (int i = 0; i < FP32_LANES; i++) begin
                r[i*32 +: 32] = ref_fmul(s0[i*32 +: 32], s1[i*32 +: 32],
                                         FP32_EXP_W, FP32_MANT_W);
            end
        end else begin
            for (int i = 0; i < FP16_LANES; i++) begin
                r[i*16 +: 16] = 16'(ref_fmul(32'(s0[i*16 +: 16]), 32'(s1[i*16 +: 16]),
                                             FP16_EXP_W, FP16_MANT_W));
            end
        end
        return r;
    endfunction

    // random normal operand around the middle of the exponent range
    // kind 1 against kind 2 gives a product exactly halfway between two values
    function automatic logic [31:0] rand_operand(input int ew, input int mw, input int kind);
        int          bias;
        logic [31:0] e;
        logic [31:0] m;
        bias = (1 << (ew - 1)) - 1;
        e    = 32'(bias / 2 + 1) + ($urandom % 32'(bias));
        m    = $urandom & ((32'd1 << mw) - 1);
        if (kind == 1) begin
            // upper half mantissa ending in binary 10
            m = ((m | (32'd1 << (mw - 1))) & ~32'd3) | 32'd2;
        end else if (kind == 2) begin
            m = 32'd1 << (mw - 1);
        end
        return (($urandom % 32'd2) << (ew + mw)) | (e << mw) | m;
    endfunction

    // ------------------------------------------------------------------------
    // checking and bus tasks
    // ------------------------------------------------------------------------

    task automatic check_value(input vec128_t got, input vec128_t want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdata);
        int n;
        n = 0;
        @(posedge clk);
        wb_i.cyc <= 1'b1;
        wb_i.stb <= 1'b1;
        wb_i.we  <= we;
        wb_i.adr <= adr;
        wb_i.dat <= dat;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_o.ack && n < TIMEOUT);
        if (!wb_o.ack) begin
            errors++;
            $display("timeout: no wishbone ack for register %0d", adr);
        end
        rdata = wb_o.dat;
        @(posedge clk);
        wb_i.cyc <= 1'b0;
        wb_i.stb <= 1'b0;
    endtask

    task automatic expect_reg(input wb_addr_t adr, input wb_data_t want, input string what);
        wb_data_t rd;
        wb_access(1'b0, adr, '0, rd);
        check_value(vec128_t'(rd), vec128_t'(want), what);
    endtask

    task automatic set_mode(input prec_mode_e m);
        wb_data_t unused;
        wb_access(1'b1, REG_MODE, wb_data_t'(m), unused);
        cur_mode = m;
    endtask

    task automatic send_req(input vec128_t s0, input vec128_t s1);
        @(posedge clk);
        req_i.valid <= 1'b1;
        req_i.s0    <= s0;
        req_i.s1    <= s1;
        exp_q.push_back(expect_vec(s0, s1, cur_mode));
        issued++;
    endtask

    task automatic end_stream();
        @(posedge clk);
        req_i.valid <= 1'b0;
    endtask

    task automatic random_req(input bit tie);
        vec128_t s0;
        vec128_t s1;
        for (int i = 0; i < FP32_LANES && cur_mode == MODE_FP32; i++) begin
            s0[i*32 +: 32] = rand_operand(FP32_EXP_W, FP32_MANT_W, tie ? 1 : 0);
            s1[i*32 +: 32] = rand_operand(FP32_EXP_W, FP32_MANT_W, tie ? 2 : 0);
        end
        for (int i = 0; i < FP16_LANES && cur_mode == MODE_FP16; i++) begin
            s0[i*16 +: 16] = 16'(rand_operand(FP16_EXP_W, FP16_MANT_W, tie ? 1 : 0));
            s1[i*16 +: 16] = 16'(rand_operand(FP16_EXP_W, FP16_MANT_W, tie ? 2 : 0));
        end
        send_req(s0, s1);
    endtask

    task automatic random_burst(input int n, input bit tie);
        repeat (n) begin
            random_req(tie);
        end
        end_stream();
    endtask

    // mode write running alongside two back-to-back requests
    task automatic switch_mid_stream(input prec_mode_e m);
        wb_data_t unused;
        fork
            wb_access(1'b1, REG_MODE, wb_data_t'(m), unused);
            begin
                // sampled on the ack edge under the old mode
                random_req(1'b0);
                cur_mode = m;
                // sampled one edge after the ack under the new mode
                random_req(1'b0);
                end_stream();
            end
        join
    endtask

    task automatic special_burst();
        send_req(SP16_A, SP16_B);
        send_req(SP32_A0, SP32_B0);
        send_req(SP32_A1, SP32_B1);
        end_stream();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d results did not come back", exp_q.size());
        end
    endtask

    task automatic finish_test(input string name);
        drain();
        $display("[done] %s, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // compare every response against the oldest expected vector
    always @(negedge clk) begin
        if (rst_n && rsp_o.valid) begin
            responses++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("response at %0t with no request outstanding", $time);
            end else begin
                check_value(rsp_o.data, exp_q.pop_front(), "result vector");
            end
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin
        wb_data_t rd;
        void'($urandom(32'ha47e1b64));
        rst_n <= 1'b0;
        wb_i  <= '0;
        req_i <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        expect_reg(REG_MODE, 32'd0, "mode after reset");
        expect_reg(REG_OPCOUNT, 32'd0, "opcount after reset");
        repeat (10) @(posedge clk);
        check_value(vec128_t'(responses), '0, "responses while idle");
        finish_test("reset state");

        random_burst(60, 1'b0);
        random_burst(20, 1'b1);
        finish_test("fp16 random");

        set_mode(MODE_FP32);
        random_burst(60, 1'b0);
        random_burst(20, 1'b1);
        // last fp32 results still in flight while the mode flips
        switch_mid_stream(MODE_FP16);
        random_burst(10, 1'b0);
        switch_mid_stream(MODE_FP32);
        random_burst(10, 1'b0);
        finish_test("fp32 random");

        special_burst();
        set_mode(MODE_FP16);
        special_burst();
        finish_test("special values");

        expect_reg(REG_OPCOUNT, 32'(issued), "opcount total");
        wb_access(1'b1, REG_OPCOUNT, '0, rd);
        issued = 0;
        random_burst(7, 1'b0);
        drain();
        expect_reg(REG_OPCOUNT, 32'(issued), "opcount after clear");
        finish_test("op counter");

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results were never matched", exp_q.size());
        end
        $display("checks %0d, errors %0d, responses %0d", checks, errors, responses);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
